// File: verilog/core_config.svh
/*
  core constants: bridge register addresses, the manual reset length,
  the coin pulse length and the analog stick thresholds.
  include wherever one of them is needed.
*/
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

////////////////////
// bridge addresses
////////////////////

`define CFG_ADDR_LIVES      32'h2000_0000
`define CFG_ADDR_DIFFICULTY 32'h3000_0000
`define CFG_ADDR_BONUS      32'h4000_0000
`define CFG_ADDR_DEMO       32'h5000_0000
`define CFG_ADDR_ADAPTER_EN 32'hF200_0000
`define CFG_ADDR_RESET      32'h8000_0000

// adapter byte: 4:0 snac type, 6:5 assignment, 7 screen blank
`define CFG_ADDR_ADAPTER    32'hF700_0000

////////////////////
// timing
////////////////////

// core reset length in clk_74a cycles
`define CORE_RESET_HOLD     64

// coin pulse length after key release
`define COIN_PULSE_CYCLES   16

// stick deadzone edges, centre near 0x7f
`define STICK_LOW           8'h40
`define STICK_HIGH          8'hC0

`endif

// File: verilog/ctrl_pkg.sv
/*
  controller and settings types shared by the settings block, the mapper
  and the testbench. covers adapter pad kinds, player routing codes, the
  manual reset FSM states and the key word bit positions.
*/
`default_nettype none

package ctrl_pkg;

    // adapter controller kind, 5-bit code from the adapter config byte
    typedef enum logic [4:0] {
        snac_none     = 5'h00,
        snac_digital  = 5'h02,
        snac_analog_a = 5'h12,
        snac_analog_b = 5'h13
    } snac_type_t;

    // which adapter pad lands on which player
    typedef enum logic [1:0] {
        snac1_to_p1   = 2'd0,
        snac1_to_p2   = 2'd1,
        both_straight = 2'd2,
        both_swapped  = 2'd3
    } cont_assign_t;

    // manual core reset FSM
    typedef enum logic {
        rst_idle = 1'b0,
        rst_hold = 1'b1
    } reset_state_t;

    // bit positions in the 16-bit key word
    localparam int unsigned key_up_bit    = 0;
    localparam int unsigned key_down_bit  = 1;
    localparam int unsigned key_left_bit  = 2;
    localparam int unsigned key_right_bit = 3;
    localparam int unsigned key_coin_bit  = 14;
    localparam int unsigned key_start_bit = 15;

endpackage

`default_nettype wire

// File: verilog/video_pkg.sv
/*
  pixel colour types for the video path. the core delivers 4 bits per
  channel, the scaler takes 8 bits per channel.
*/
`default_nettype none

package video_pkg;

    // core colour, r in 11:8, g in 7:4, b in 3:0
    typedef logic [11:0] rgb444_t;

    // scaler colour, r in 23:16, g in 15:8, b in 7:0
    typedef logic [23:0] rgb888_t;

endpackage

`default_nettype wire

// File: verilog/bridge_settings.sv
/*
  game and adapter settings written over the bridge, with readback.
  packs the game settings into the dip word and turns each toggle of the
  reset request into a core reset of fixed length.
*/
`timescale 1ns/10ps
`default_nettype none

module bridge_settings (
    input  logic                   clk_74a,
    input  logic                   reset,
    input  logic [31:0]            bridge_addr,
    input  logic                   bridge_rd,
    input  logic                   bridge_wr,
    input  logic [31:0]            bridge_wr_data,
    output logic [31:0]            bridge_rd_data,
    output logic [15:0]            dip_switches,
    output logic                   adapter_en,
    output ctrl_pkg::snac_type_t   snac_type,
    output ctrl_pkg::cont_assign_t cont_assign,
    output logic                   blank_screen,
    output logic                   core_reset
);
    import ctrl_pkg::*;

    `include "core_config.svh"

    localparam int hold_w = $clog2(`CORE_RESET_HOLD);

    logic [1:0]        cs_lives;
    logic [2:0]        cs_difficulty;
    logic [2:0]        cs_bonus;
    logic              cs_demo;
    logic [7:0]        adapter_cfg;
    logic              reset_req;
    logic              reset_req_prev;
    logic [31:0]       rd_mux;
    reset_state_t      rst_state;
    logic [hold_w-1:0] hold_cnt;

    ////////////////////
    // register writes
    ////////////////////

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            cs_lives      <= '0;
            cs_difficulty <= '0;
            cs_bonus      <= '0;
            cs_demo       <= 1'b0;
            adapter_en    <= 1'b0;
            adapter_cfg   <= '0;
            reset_req     <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                `CFG_ADDR_LIVES:      cs_lives      <= bridge_wr_data[1:0];
                `CFG_ADDR_DIFFICULTY: cs_difficulty <= bridge_wr_data[2:0];
                `CFG_ADDR_BONUS:      cs_bonus      <= bridge_wr_data[2:0];
                `CFG_ADDR_DEMO:       cs_demo       <= bridge_wr_data[0];
                `CFG_ADDR_ADAPTER_EN: adapter_en    <= bridge_wr_data[0];
                `CFG_ADDR_ADAPTER:    adapter_cfg   <= bridge_wr_data[7:0];
                // any write here flips the request, data ignored
                `CFG_ADDR_RESET:      reset_req     <= ~reset_req;
                default: ;
            endcase
        end
    end

    // demo sounds on top, lives mid, difficulty and bonus low
    assign dip_switches = {cs_demo, 1'b0, cs_lives, 6'b0, cs_difficulty, cs_bonus};

    // adapter byte split
    assign snac_type    = snac_type_t'(adapter_cfg[4:0]);
    assign cont_assign  = cont_assign_t'(adapter_cfg[6:5]);
    assign blank_screen = adapter_cfg[7];

    ////////////////////
    // read mux
    ////////////////////

    // fields right aligned, reset address reads zero
    always_comb begin
        case (bridge_addr)
            `CFG_ADDR_LIVES:      rd_mux = {30'd0, cs_lives};
            `CFG_ADDR_DIFFICULTY: rd_mux = {29'd0, cs_difficulty};
            `CFG_ADDR_BONUS:      rd_mux = {29'd0, cs_bonus};
            `CFG_ADDR_DEMO:       rd_mux = {31'd0, cs_demo};
            `CFG_ADDR_ADAPTER_EN: rd_mux = {31'd0, adapter_en};
            `CFG_ADDR_ADAPTER:    rd_mux = {24'd0, adapter_cfg};
            default:              rd_mux = 32'd0;
        endcase
    end

    // data only presented while the bus reads
    assign bridge_rd_data = bridge_rd ? rd_mux : 32'd0;

    ////////////////////
    // manual reset
    ////////////////////

    // system reset lands in hold, so the core stays in reset a while after
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            rst_state      <= rst_hold;
            hold_cnt       <= hold_w'(`CORE_RESET_HOLD - 1);
            reset_req_prev <= 1'b0;
        end else begin
            // tracked every cycle so toggles during hold are absorbed
            reset_req_prev <= reset_req;
            case (rst_state)
                rst_idle: begin
                    if (reset_req != reset_req_prev) begin
                        rst_state <= rst_hold;
                        hold_cnt  <= hold_w'(`CORE_RESET_HOLD - 1);
                    end
                end
                rst_hold: begin
                    if (hold_cnt == '0) begin
                        rst_state <= rst_idle;
                    end else begin
                        hold_cnt <= hold_cnt - 1'b1;
                    end
                end
                default: rst_state <= rst_idle;
            endcase
        end
    end

    assign core_reset = (rst_state == rst_hold);

endmodule

`default_nettype wire

// File: verilog/control_mapper.sv
/*
  player control mapping. picks pocket keys or adapter pads, converts
  analog sticks to d-pad bits and routes pads by the assignment code.
  also stretches the release of p1's coin key into a long pulse.
*/
`timescale 1ns/10ps
`default_nettype none

module control_mapper (
    input  logic                   clk_74a,
    input  logic                   reset,
    input  logic [15:0]            cont1_key,
    input  logic [15:0]            cont2_key,
    input  logic [15:0]            snac_p1_btn,
    input  logic [15:0]            snac_p2_btn,
    input  logic [31:0]            snac_p1_joy,
    input  logic [31:0]            snac_p2_joy,
    input  logic                   adapter_en,
    input  ctrl_pkg::snac_type_t   snac_type,
    input  ctrl_pkg::cont_assign_t cont_assign,
    output logic [15:0]            p1_controls,
    output logic [15:0]            p2_controls,
    output logic                   coin_pulse
);
    import ctrl_pkg::*;

    `include "core_config.svh"

    localparam int coin_w = $clog2(`COIN_PULSE_CYCLES + 1);

    logic              snac_is_analog;
    logic              snac_active;
    logic [15:0]       pad1;
    logic [15:0]       pad2;
    logic [15:0]       p1_next;
    logic [15:0]       p2_next;
    logic              coin_prev;
    logic [coin_w-1:0] coin_cnt;

    // analog pads: left stick overrides the d-pad bits
    // y in 15:8, x in 7:0, small is up/left
    function automatic logic [15:0] pad_dpad(
        input logic [15:0] btn,
        input logic [31:0] joy,
        input logic        analog
    );
        logic [15:0] pad;
        pad = btn;
        if (analog) begin
            pad[key_up_bit]    = (joy[15:8] < `STICK_LOW);
            pad[key_down_bit]  = (joy[15:8] > `STICK_HIGH);
            pad[key_left_bit]  = (joy[7:0] < `STICK_LOW);
            pad[key_right_bit] = (joy[7:0] > `STICK_HIGH);
        end
        return pad;
    endfunction

    assign snac_is_analog = (snac_type == snac_analog_a) || (snac_type == snac_analog_b);
    assign snac_active    = adapter_en && (snac_type != snac_none);

    assign pad1 = pad_dpad(snac_p1_btn, snac_p1_joy, snac_is_analog);
    assign pad2 = pad_dpad(snac_p2_btn, snac_p2_joy, snac_is_analog);

    ////////////////////
    // player routing
    ////////////////////

    always_comb begin
        p1_next = cont1_key;
        p2_next = cont2_key;
        if (snac_active) begin
            case (cont_assign)
                snac1_to_p1: begin
                    p1_next = pad1;
                    p2_next = cont1_key;
                end
                snac1_to_p2: begin
                    // p2 sees the raw pad buttons, no stick override
                    p1_next = cont1_key;
                    p2_next = snac_p1_btn;
                end
                both_straight: begin
                    p1_next = pad1;
                    p2_next = pad2;
                end
                both_swapped: begin
                    p1_next = pad2;
                    p2_next = pad1;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            p1_controls <= '0;
            p2_controls <= '0;
        end else begin
            p1_controls <= p1_next;
            p2_controls <= p2_next;
        end
    end

    ////////////////////
    // coin stretcher
    ////////////////////

    // release loads the counter, pulse while nonzero
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            coin_prev <= 1'b0;
            coin_cnt  <= '0;
        end else begin
            coin_prev <= p1_controls[key_coin_bit];
            if (coin_cnt != '0) begin
                coin_cnt <= coin_cnt - 1'b1;
            end else if (coin_prev && !p1_controls[key_coin_bit]) begin
                coin_cnt <= coin_w'(`COIN_PULSE_CYCLES);
            end
        end
    end

    assign coin_pulse = (coin_cnt != '0);

endmodule

`default_nettype wire

// File: verilog/video_formatter.sv
/*
  video output stage. expands 4-bit channels to 8 bits, derives data
  enable from the blanks, turns sync rises into one-cycle pulses and
  blanks the picture when the adapter asks for it.
*/
`timescale 1ns/10ps
`default_nettype none

module video_formatter (
    input  logic                clk_74a,
    input  logic                reset,
    input  video_pkg::rgb444_t  core_rgb,
    input  logic                hblank_in,
    input  logic                vblank_in,
    input  logic                hs_in,
    input  logic                vs_in,
    input  logic                blank_screen,
    input  logic                adapter_en,
    output video_pkg::rgb888_t  video_rgb,
    output logic                video_de,
    output logic                video_hs,
    output logic                video_vs
);
    import video_pkg::*;

    rgb888_t    rgb_wide;
    logic       pix_blank;
    logic       force_black;
    logic [1:0] sync_prev;

    // nibble duplication, 0xf maps to 0xff
    assign rgb_wide = {{2{core_rgb[11:8]}}, {2{core_rgb[7:4]}}, {2{core_rgb[3:0]}}};

    assign pix_blank   = hblank_in | vblank_in;
    assign force_black = blank_screen & adapter_en;

    // colour path
    always_ff @(posedge clk_74a) begin
        if (pix_blank || force_black) begin
            video_rgb <= '0;
        end else begin
            video_rgb <= rgb_wide;
        end
    end

    ////////////////////
    // de and sync
    ////////////////////

    // de ignores screen blank, the scaler still needs the frame shape
    // vs in bit 1, hs in bit 0
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
            sync_prev <= '0;
        end else begin
            video_de               <= ~pix_blank;
            {video_vs, video_hs}   <= {vs_in, hs_in} & ~sync_prev;
            sync_prev              <= {vs_in, hs_in};
        end
    end

endmodule

`default_nettype wire

// File: verilog/core_top.sv
/*
  top level of the settings, controls and video path. the bridge settings
  feed the control mapper and the video formatter, all on clk_74a.
*/
`timescale 1ns/10ps
`default_nettype none

module core_top (
    input  logic               clk_74a,
    input  logic               reset,

    // bridge
    input  logic [31:0]        bridge_addr,
    input  logic               bridge_rd,
    input  logic               bridge_wr,
    input  logic [31:0]        bridge_wr_data,
    output logic [31:0]        bridge_rd_data,

    // game settings and core reset
    output logic [15:0]        dip_switches,
    output logic               core_reset,

    // controllers
    input  logic [15:0]        cont1_key,
    input  logic [15:0]        cont2_key,
    input  logic [15:0]        snac_p1_btn,
    input  logic [15:0]        snac_p2_btn,
    input  logic [31:0]        snac_p1_joy,
    input  logic [31:0]        snac_p2_joy,
    output logic [15:0]        p1_controls,
    output logic [15:0]        p2_controls,
    output logic               coin_pulse,

    // video
    input  video_pkg::rgb444_t core_rgb,
    input  logic               hblank_in,
    input  logic               vblank_in,
    input  logic               hs_in,
    input  logic               vs_in,
    output video_pkg::rgb888_t video_rgb,
    output logic               video_de,
    output logic               video_hs,
    output logic               video_vs
);
    import ctrl_pkg::*;

    // adapter config from the settings block
    logic         adapter_en;
    snac_type_t   snac_type;
    cont_assign_t cont_assign;
    logic         blank_screen;

    bridge_settings u_bridge_settings (
        .clk_74a        (clk_74a),
        .reset          (reset),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .dip_switches   (dip_switches),
        .adapter_en     (adapter_en),
        .snac_type      (snac_type),
        .cont_assign    (cont_assign),
        .blank_screen   (blank_screen),
        .core_reset     (core_reset)
    );

    control_mapper u_control_mapper (
        .clk_74a     (clk_74a),
        .reset       (reset),
        .cont1_key   (cont1_key),
        .cont2_key   (cont2_key),
        .snac_p1_btn (snac_p1_btn),
        .snac_p2_btn (snac_p2_btn),
        .snac_p1_joy (snac_p1_joy),
        .snac_p2_joy (snac_p2_joy),
        .adapter_en  (adapter_en),
        .snac_type   (snac_type),
        .cont_assign (cont_assign),
        .p1_controls (p1_controls),
        .p2_controls (p2_controls),
        .coin_pulse  (coin_pulse)
    );

    video_formatter u_video_formatter (
        .clk_74a      (clk_74a),
        .reset        (reset),
        .core_rgb     (core_rgb),
        .hblank_in    (hblank_in),
        .vblank_in    (vblank_in),
        .hs_in        (hs_in),
        .vs_in        (vs_in),
        .blank_screen (blank_screen),
        .adapter_en   (adapter_en),
        .video_rgb    (video_rgb),
        .video_de     (video_de),
        .video_hs     (video_hs),
        .video_vs     (video_vs)
    );

endmodule

`default_nettype wire

// File: sim/core_assertions.sv
/*
  concurrent checks on the core_top ports and its adapter config nets.
  bound to core_top from the testbench, failures counted in fail_count.
*/
`timescale 1ns/10ps
`default_nettype none

module core_assertions (
    input logic                   clk_74a,
    input logic                   reset,
    input logic [31:0]            bridge_addr,
    input logic                   bridge_wr,
    input logic                   core_reset,
    input logic [15:0]            cont1_key,
    input logic [15:0]            cont2_key,
    input logic [15:0]            snac_p1_btn,
    input logic [15:0]            snac_p2_btn,
    input logic [31:0]            snac_p1_joy,
    input logic [31:0]            snac_p2_joy,
    input logic [15:0]            p1_controls,
    input logic [15:0]            p2_controls,
    input logic                   coin_pulse,
    input logic                   adapter_en,
    input ctrl_pkg::snac_type_t   snac_type,
    input ctrl_pkg::cont_assign_t cont_assign,
    input logic                   blank_screen,
    input video_pkg::rgb444_t     core_rgb,
    input logic                   hblank_in,
    input logic                   vblank_in,
    input logic                   hs_in,
    input logic                   vs_in,
    input video_pkg::rgb888_t     video_rgb,
    input logic                   video_de,
    input logic                   video_hs,
    input logic                   video_vs
);
    import ctrl_pkg::*;
    import video_pkg::*;

    `include "core_config.svh"

    int          fail_count = 0;
    int          rst_run;
    int          coin_run;
    logic        wr_rst;
    logic        analog;
    logic        pads_on;
    logic [15:0] exp_p1;
    logic [15:0] exp_p2;
    rgb888_t     exp_rgb;

    // stick override of the d-pad, small value is up or left
    function automatic logic [15:0] stick_pad(
        input logic [15:0] btn,
        input logic [31:0] joy,
        input logic        use_stick
    );
        logic [15:0] r;
        r = btn;
        if (use_stick) begin
            r[key_up_bit]    = joy[15:8] < `STICK_LOW;
            r[key_down_bit]  = joy[15:8] > `STICK_HIGH;
            r[key_left_bit]  = joy[7:0] < `STICK_LOW;
            r[key_right_bit] = joy[7:0] > `STICK_HIGH;
        end
        return r;
    endfunction

    assign wr_rst  = bridge_wr && (bridge_addr == `CFG_ADDR_RESET);
    assign analog  = (snac_type == snac_analog_a) || (snac_type == snac_analog_b);
    assign pads_on = adapter_en && (snac_type != snac_none);

    // expected routing for the next cycle
    always_comb begin
        exp_p1 = cont1_key;
        exp_p2 = cont2_key;
        if (pads_on) begin
            case (cont_assign)
                snac1_to_p1: begin
                    exp_p1 = stick_pad(snac_p1_btn, snac_p1_joy, analog);
                    exp_p2 = cont1_key;
                end
                snac1_to_p2: begin
                    exp_p2 = snac_p1_btn;
                end
                both_straight: begin
                    exp_p1 = stick_pad(snac_p1_btn, snac_p1_joy, analog);
                    exp_p2 = stick_pad(snac_p2_btn, snac_p2_joy, analog);
                end
                default: begin
                    exp_p1 = stick_pad(snac_p2_btn, snac_p2_joy, analog);
                    exp_p2 = stick_pad(snac_p1_btn, snac_p1_joy, analog);
                end
            endcase
        end
    end

    // each channel is its nibble times 0x11
    // black in blanking or on screen blank
    always_comb begin
        exp_rgb = {8'(core_rgb[11:8]) * 8'h11, 8'(core_rgb[7:4]) * 8'h11,
                   8'(core_rgb[3:0]) * 8'h11};
        if (hblank_in || vblank_in || (blank_screen && adapter_en)) begin
            exp_rgb = '0;
        end
    end

    // lengths of high runs
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            rst_run  <= 0;
            coin_run <= 0;
        end else begin
            rst_run  <= core_reset ? rst_run + 1 : 0;
            coin_run <= coin_pulse ? coin_run + 1 : 0;
        end
    end

    ////////////////////
    // manual reset
    ////////////////////

    a_rst_rise: assert property (@(posedge clk_74a) disable iff (reset)
        $past(wr_rst && !core_reset, 2) |-> core_reset && !$past(core_reset))
        else begin
            fail_count++;
            $error("error at %0t: core_reset got %b expected 1", $time, core_reset);
        end

    a_rst_len: assert property (@(posedge clk_74a) disable iff (reset)
        (!core_reset && $past(core_reset)) |-> rst_run == `CORE_RESET_HOLD)
        else begin
            fail_count++;
            $error("error at %0t: core_reset length got %0d expected %0d",
                   $time, rst_run, `CORE_RESET_HOLD);
        end

    ////////////////////
    // controls and coin
    ////////////////////

    a_p1: assert property (@(posedge clk_74a) disable iff (reset)
        !$past(reset) |-> p1_controls == $past(exp_p1))
        else begin
            fail_count++;
            $error("error at %0t: p1_controls got %h expected %h",
                   $time, p1_controls, $past(exp_p1));
        end

    a_p2: assert property (@(posedge clk_74a) disable iff (reset)
        !$past(reset) |-> p2_controls == $past(exp_p2))
        else begin
            fail_count++;
            $error("error at %0t: p2_controls got %h expected %h",
                   $time, p2_controls, $past(exp_p2));
        end

    // a release while idle starts the pulse one cycle later
    a_coin_start: assert property (@(posedge clk_74a) disable iff (reset)
        (!$past(reset, 2) && !$past(reset) && $past(p1_controls[key_coin_bit], 2)
         && !$past(p1_controls[key_coin_bit]) && !$past(coin_pulse)) |-> coin_pulse)
        else begin
            fail_count++;
            $error("error at %0t: coin_pulse got %b expected 1", $time, coin_pulse);
        end

    a_coin_len: assert property (@(posedge clk_74a) disable iff (reset)
        (!coin_pulse && $past(coin_pulse)) |-> coin_run == `COIN_PULSE_CYCLES)
        else begin
            fail_count++;
            $error("error at %0t: coin_pulse length got %0d expected %0d",
                   $time, coin_run, `COIN_PULSE_CYCLES);
        end

    ////////////////////
    // video
    ////////////////////

    a_de: assert property (@(posedge clk_74a) disable iff (reset)
        !$past(reset) |-> video_de == !$past(hblank_in || vblank_in))
        else begin
            fail_count++;
            $error("error at %0t: video_de got %b expected %b",
                   $time, video_de, !$past(hblank_in || vblank_in));
        end

    a_rgb: assert property (@(posedge clk_74a) disable iff (reset)
        !$past(reset) |-> video_rgb == $past(exp_rgb))
        else begin
            fail_count++;
            $error("error at %0t: video_rgb got %h expected %h",
                   $time, video_rgb, $past(exp_rgb));
        end

    a_hs: assert property (@(posedge clk_74a) disable iff (reset)
        (!$past(reset) && !$past(reset, 2))
        |-> video_hs == ($past(hs_in) && !$past(hs_in, 2)))
        else begin
            fail_count++;
            $error("error at %0t: video_hs got %b expected %b",
                   $time, video_hs, $past(hs_in) && !$past(hs_in, 2));
        end

    a_vs: assert property (@(posedge clk_74a) disable iff (reset)
        (!$past(reset) && !$past(reset, 2))
        |-> video_vs == ($past(vs_in) && !$past(vs_in, 2)))
        else begin
            fail_count++;
            $error("error at %0t: video_vs got %b expected %b",
                   $time, video_vs, $past(vs_in) && !$past(vs_in, 2));
        end

endmodule

`default_nettype wire

// File: sim/tb_core_top.sv
/*
  testbench for core_top. checks settings readback here, everything else
  in the bound assertion module, with LFSR driven keys, sticks and pixels.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_core_top;
    import ctrl_pkg::*;

    `include "core_config.svh"

    logic        clk_74a = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] bridge_addr = '0;
    logic        bridge_rd = 1'b0;
    logic        bridge_wr = 1'b0;
    logic [31:0] bridge_wr_data = '0;
    logic [31:0] bridge_rd_data;
    logic [15:0] dip_switches;
    logic        core_reset;
    logic [15:0] cont1_key = '0;
    logic [15:0] cont2_key = '0;
    logic [15:0] snac_p1_btn = '0;
    logic [15:0] snac_p2_btn = '0;
    logic [31:0] snac_p1_joy = '0;
    logic [31:0] snac_p2_joy = '0;
    logic [15:0] p1_controls;
    logic [15:0] p2_controls;
    logic        coin_pulse;
    logic [11:0] core_rgb = '0;
    logic        hblank_in = 1'b0;
    logic        vblank_in = 1'b0;
    logic        hs_in = 1'b0;
    logic        vs_in = 1'b0;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_hs;
    logic        video_vs;

    logic [31:0] lfsr = 32'hd11b_3d1d;
    int          errors = 0;
    int          total;
    logic [31:0] wdata;
    logic [1:0]  lives;
    logic [2:0]  diff;
    logic [2:0]  bonus;
    logic        demo;
    logic [15:0] exp_dip;
    snac_type_t  pad_types [3];

    // 25 MHz stand-in for the 74.25 MHz clock
    always #20 clk_74a = ~clk_74a;

    core_top u_core_top (.*);

    bind core_top core_assertions u_core_assertions (.*);

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk_74a);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr      = 1'b0;
    endtask

    // read mux is combinational, sample mid cycle
    task automatic check_read(input logic [31:0] addr, input logic [31:0] exp);
        @(negedge clk_74a);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        #5;
        assert (bridge_rd_data == exp) else begin
            errors++;
            $display("error at %0t: bridge_rd_data[%h] got %h expected %h",
                     $time, addr, bridge_rd_data, exp);
        end
        @(negedge clk_74a);
        bridge_rd = 1'b0;
    endtask

    // one cycle of random keys, sticks and video
    task automatic drive_random();
        @(negedge clk_74a);
        cont1_key   = 16'(rand_bits(16));
        cont2_key   = 16'(rand_bits(16));
        snac_p1_btn = 16'(rand_bits(16));
        snac_p2_btn = 16'(rand_bits(16));
        snac_p1_joy = rand_bits(32);
        snac_p2_joy = rand_bits(32);
        core_rgb    = 12'(rand_bits(12));
        hblank_in   = (rand_bits(2) == 0);
        vblank_in   = (rand_bits(3) == 0);
        hs_in       = rand_bits(1) != 0;
        vs_in       = rand_bits(1) != 0;
    endtask

    task automatic wait_level(input logic want_coin, input logic level, input int limit);
        int n;
        n = 0;
        while (((want_coin ? coin_pulse : core_reset) !== level) && n < limit) begin
            @(negedge clk_74a);
            n++;
        end
        if (n >= limit) begin
            errors++;
            $display("timeout: %s did not reach %b", want_coin ? "coin_pulse" : "core_reset",
                     level);
        end
    endtask

    initial begin
        pad_types[0] = snac_digital;
        pad_types[1] = snac_analog_a;
        pad_types[2] = snac_analog_b;

        repeat (16) @(negedge clk_74a);
        reset = 1'b0;
        wait_level(1'b0, 1'b0, 200);

        //////////////////////
        // settings readback
        //////////////////////
        wdata = rand_bits(32);
        lives = wdata[1:0];
        bus_write(`CFG_ADDR_LIVES, wdata);
        check_read(`CFG_ADDR_LIVES, {30'd0, lives});
        wdata = rand_bits(32);
        diff  = wdata[2:0];
        bus_write(`CFG_ADDR_DIFFICULTY, wdata);
        check_read(`CFG_ADDR_DIFFICULTY, {29'd0, diff});
        wdata = rand_bits(32);
        bonus = wdata[2:0];
        bus_write(`CFG_ADDR_BONUS, wdata);
        check_read(`CFG_ADDR_BONUS, {29'd0, bonus});
        wdata = rand_bits(32);
        demo  = wdata[0];
        bus_write(`CFG_ADDR_DEMO, wdata);
        check_read(`CFG_ADDR_DEMO, {31'd0, demo});
        wdata = rand_bits(32);
        bus_write(`CFG_ADDR_ADAPTER, wdata);
        check_read(`CFG_ADDR_ADAPTER, {24'd0, wdata[7:0]});
        wdata = rand_bits(32);
        bus_write(`CFG_ADDR_ADAPTER_EN, wdata);
        check_read(`CFG_ADDR_ADAPTER_EN, {31'd0, wdata[0]});
        check_read(`CFG_ADDR_RESET, 32'h0);
        check_read(32'h1234_5678, 32'h0);

        // demo 15, lives 13:12, difficulty 5:3, bonus 2:0
        exp_dip = (16'(demo) << 15) | (16'(lives) << 12) | (16'(diff) << 3) | 16'(bonus);
        assert (dip_switches == exp_dip) else begin
            errors++;
            $display("error at %0t: dip_switches got %h expected %h", $time,
                     dip_switches, exp_dip);
        end

        // manual reset, length checked by assertion
        bus_write(`CFG_ADDR_RESET, 32'h0);
        wait_level(1'b0, 1'b1, 10);
        wait_level(1'b0, 1'b0, 200);

        //////////////////////
        // controls and video
        //////////////////////
        bus_write(`CFG_ADDR_ADAPTER_EN, 32'h0);
        repeat (40) drive_random();
        bus_write(`CFG_ADDR_ADAPTER_EN, 32'h1);
        for (int t = 0; t < 3; t++) begin
            for (int a = 0; a < 4; a++) begin
                // screen blank on for odd routing codes
                bus_write(`CFG_ADDR_ADAPTER, {24'd0, a[0], a[1:0], 5'(pad_types[t])});
                repeat (30) drive_random();
            end
        end

        // coin release with the pocket keys
        bus_write(`CFG_ADDR_ADAPTER_EN, 32'h0);
        @(negedge clk_74a);
        cont1_key = '0;
        repeat (20) @(negedge clk_74a);
        cont1_key[key_coin_bit] = 1'b1;
        repeat (3) @(negedge clk_74a);
        cont1_key[key_coin_bit] = 1'b0;
        wait_level(1'b1, 1'b1, 10);
        wait_level(1'b1, 1'b0, 40);
        repeat (5) @(negedge clk_74a);

        total = errors + u_core_top.u_core_assertions.fail_count;
        $display("errors: testbench %0d, assertions %0d", errors,
                 u_core_top.u_core_assertions.fail_count);
        if (total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+verilog
verilog/ctrl_pkg.sv
verilog/video_pkg.sv
verilog/bridge_settings.sv
verilog/control_mapper.sv
verilog/video_formatter.sv
verilog/core_top.sv
sim/core_assertions.sv
sim/tb_core_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the core_top testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_core_top -f build.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
exit 0
